// ==== rtl/digit_glyph_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "thermal_display_macros.svh"

module digit_glyph_rom (
  input  wire thermal_display_pkg::bcd_digit_t i_digit,
  input  wire thermal_display_pkg::cell_x_t    i_cell_x,
  input  wire thermal_display_pkg::cell_y_t    i_cell_y,
  output logic                                 o_glyph_on
);

  logic       left_col, mid_col, right_col;
  logic       top_row, upper_row, mid_row, lower_row, bottom_row;
  logic [6:0] seg_hit;   // bit 0 = a ... bit 6 = g
  logic [6:0] seg_lit;

  // column bands of the cell
  assign left_col  = i_cell_x < `SEG_W;
  assign mid_col   = (i_cell_x >= `SEG_W) && (i_cell_x < `CELL_W - `SEG_W);
  assign right_col = (i_cell_x >= `CELL_W - `SEG_W) && (i_cell_x < `CELL_W);

  // row bands, verticals split at the cell centre
  assign top_row    = i_cell_y < `SEG_W;
  assign upper_row  = (i_cell_y >= `SEG_W) && (i_cell_y < `CELL_H / 2);
  assign lower_row  = (i_cell_y >= `CELL_H / 2) && (i_cell_y < `CELL_H - `SEG_W);
  assign bottom_row = (i_cell_y >= `CELL_H - `SEG_W) && (i_cell_y < `CELL_H);
  assign mid_row    = (i_cell_y >= `MID_TOP) && (i_cell_y <= `MID_BOT); // overlaps b/c, f/e rows

  assign seg_hit[0] = mid_col && top_row;       // a
  assign seg_hit[1] = right_col && upper_row;   // b
  assign seg_hit[2] = right_col && lower_row;   // c
  assign seg_hit[3] = mid_col && bottom_row;    // d
  assign seg_hit[4] = left_col && lower_row;    // e
  assign seg_hit[5] = left_col && upper_row;    // f
  assign seg_hit[6] = mid_col && mid_row;       // g

  // segment sets, gfedcba
  always_comb begin
    case (i_digit)
      4'd0:    seg_lit = 7'b0111111;
      4'd1:    seg_lit = 7'b0000110;
      4'd2:    seg_lit = 7'b1011011;
      4'd3:    seg_lit = 7'b1001111;
      4'd4:    seg_lit = 7'b1100110;
      4'd5:    seg_lit = 7'b1101101;
      4'd6:    seg_lit = 7'b1111101; // 6 adds e over 5
      4'd7:    seg_lit = 7'b0000111; // 7 adds a over 1
      4'd8:    seg_lit = 7'b1111111;
      4'd9:    seg_lit = 7'b1101111;
      default: seg_lit = 7'b0000000; // not a digit, blank glyph
    endcase
  end

  assign o_glyph_on = |(seg_hit & seg_lit);

endmodule

`default_nettype wire

// ==== rtl/pixel_composer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "thermal_display_macros.svh"

module pixel_composer (
  input  wire                                     pixel_clk,
  input  wire                                     i_reset,
  input  wire thermal_display_pkg::display_mode_t  i_mode,
  input  wire thermal_display_pkg::screen_region_t i_region,
  input  wire thermal_display_pkg::bcd_digit_t     i_digit,
  input  wire                                     i_glyph_on,
  input  wire thermal_display_pkg::color_chan_t    i_tint_red,
  input  wire thermal_display_pkg::color_chan_t    i_tint_green,
  input  wire thermal_display_pkg::color_chan_t    i_tint_blue,
  output thermal_display_pkg::color_chan_t         o_red,
  output thermal_display_pkg::color_chan_t         o_green,
  output thermal_display_pkg::color_chan_t         o_blue
);

  logic        in_digit_cell;
  logic [11:0] nxt_rgb;

  assign in_digit_cell = (i_region == thermal_display_pkg::REGION_TENS) ||
                         (i_region == thermal_display_pkg::REGION_ONES);

  always_comb begin
    if (i_mode != thermal_display_pkg::MODE_WORKING) begin
      nxt_rgb = `BLACK_RGB;  // shutdown and every unused code
    end else if (i_region == thermal_display_pkg::REGION_FIRE) begin
      nxt_rgb = `FIRE_RGB;
    end else if (i_region == thermal_display_pkg::REGION_WARNING) begin
      nxt_rgb = `WARN_RGB;
    end else if (in_digit_cell && (i_digit > 4'd9)) begin
      nxt_rgb = `WHITE_RGB;  // bad sensor digit shows as a solid box
    end else if ((i_region == thermal_display_pkg::REGION_TENS) && (i_digit == 4'd0)) begin
      nxt_rgb = `BLACK_RGB;  // no leading zero
    end else if (in_digit_cell && i_glyph_on) begin
      nxt_rgb = {i_tint_red, i_tint_green, i_tint_blue};
    end else begin
      nxt_rgb = `BLACK_RGB;  // unlit glyph pixel or background
    end
  end

  // stage 2, drives the dac pins
  always_ff @(posedge pixel_clk) begin
    if (i_reset) begin
      o_red   <= '0;
      o_green <= '0;
      o_blue  <= '0;
    end else begin
      o_red   <= nxt_rgb[11:8];
      o_green <= nxt_rgb[7:4];
      o_blue  <= nxt_rgb[3:0];
    end
  end

  // shutdown pixel must come out black on the next edge
  a_shutdown_black: assert property (@(posedge pixel_clk) disable iff (i_reset)
    (i_mode == thermal_display_pkg::MODE_SHUTDOWN)
    |=> ((o_red == '0) && (o_green == '0) && (o_blue == '0)));

endmodule

`default_nettype wire

// ==== rtl/pixel_input_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "thermal_display_macros.svh"

module pixel_input_stage (
  input  wire                                 pixel_clk,
  input  wire                                 i_reset,
  input  wire thermal_display_pkg::coord_x_t  i_x,
  input  wire thermal_display_pkg::coord_y_t  i_y,
  input  wire thermal_display_pkg::display_mode_t i_mode,
  input  wire thermal_display_pkg::bcd_digit_t i_tens,
  input  wire thermal_display_pkg::bcd_digit_t i_ones,
  input  wire                                 i_fire,
  input  wire                                 i_warning,
  output thermal_display_pkg::display_mode_t  o_mode,
  output thermal_display_pkg::screen_region_t o_region,
  output thermal_display_pkg::cell_x_t        o_cell_x,
  output thermal_display_pkg::cell_y_t        o_cell_y,
  output thermal_display_pkg::bcd_digit_t     o_digit,
  output thermal_display_pkg::bcd_digit_t     o_tens,
  output thermal_display_pkg::bcd_digit_t     o_ones
);

  logic in_alarm_row, in_digit_row;
  logic in_fire, in_warn, in_tens, in_ones;
  thermal_display_pkg::screen_region_t nxt_region;
  thermal_display_pkg::coord_x_t       tens_x_off, ones_x_off; // full width before trim
  thermal_display_pkg::coord_y_t       digit_y_off;

  assign in_alarm_row = (i_y >= `ALARM_Y_MIN) && (i_y <= `ALARM_Y_MAX);
  assign in_digit_row = (i_y >= `DIGIT_Y_MIN) && (i_y <= `DIGIT_Y_MAX);

  // alarm boxes only exist while their flag is up
  assign in_fire = i_fire && in_alarm_row && (i_x >= `FIRE_X_MIN) && (i_x <= `FIRE_X_MAX);
  assign in_warn = i_warning && in_alarm_row &&
                   (i_x >= `WARN_X_MIN) && (i_x <= `WARN_X_MAX);
  assign in_tens = in_digit_row && (i_x >= `TENS_X_MIN) && (i_x <= `TENS_X_MAX);
  assign in_ones = in_digit_row && (i_x >= `ONES_X_MIN) && (i_x <= `ONES_X_MAX);

  // glyph-local offsets, only meaningful inside a digit cell
  assign tens_x_off  = i_x - thermal_display_pkg::coord_x_t'(`TENS_X_MIN);
  assign ones_x_off  = i_x - thermal_display_pkg::coord_x_t'(`ONES_X_MIN);
  assign digit_y_off = i_y - thermal_display_pkg::coord_y_t'(`DIGIT_Y_MIN);

  // fire wins over warning, then the two digit cells
  always_comb begin
    if (in_fire)      nxt_region = thermal_display_pkg::REGION_FIRE;
    else if (in_warn) nxt_region = thermal_display_pkg::REGION_WARNING;
    else if (in_tens) nxt_region = thermal_display_pkg::REGION_TENS;
    else if (in_ones) nxt_region = thermal_display_pkg::REGION_ONES;
    else              nxt_region = thermal_display_pkg::REGION_NONE;
  end

  // control part of stage 1
  always_ff @(posedge pixel_clk) begin
    if (i_reset) begin
      o_mode   <= thermal_display_pkg::MODE_SHUTDOWN;
      o_region <= thermal_display_pkg::REGION_NONE;
    end else begin
      o_mode   <= i_mode;
      o_region <= nxt_region;
    end
  end

  // payload, follows the pixel
  always_ff @(posedge pixel_clk) begin
    o_cell_x <= in_tens ? tens_x_off[6:0] : ones_x_off[6:0];
    o_cell_y <= digit_y_off[6:0];
    o_digit  <= in_tens ? i_tens : i_ones; // ones digit unless in tens cell
    o_tens   <= i_tens;
    o_ones   <= i_ones;
  end

  // cell column must land inside the glyph box
  a_cell_x_in_range: assert property (@(posedge pixel_clk) disable iff (i_reset)
    (o_region inside {thermal_display_pkg::REGION_TENS, thermal_display_pkg::REGION_ONES})
    |-> (o_cell_x < `CELL_W));

endmodule

`default_nettype wire

// ==== rtl/temp_color_map.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "thermal_display_macros.svh"

module temp_color_map (
  input  wire thermal_display_pkg::bcd_digit_t i_tens,
  input  wire thermal_display_pkg::bcd_digit_t i_ones,
  output thermal_display_pkg::color_chan_t     o_red,
  output thermal_display_pkg::color_chan_t     o_green,
  output thermal_display_pkg::color_chan_t     o_blue
);

  logic [11:0] tint;  // red,green,blue nibbles

  // bcd pair reads directly as the temperature in hex
  always_comb begin
    case ({i_tens, i_ones})
      8'h27:   tint = 12'h0f8; // cool end, green
      8'h28:   tint = 12'h9f9;
      8'h29:   tint = 12'hcf4;
      8'h30:   tint = 12'hffc;
      8'h31:   tint = 12'hfe8;
      8'h32:   tint = 12'hfd0;
      8'h33:   tint = 12'hfa0;
      8'h34:   tint = 12'hf80;
      8'h35:   tint = 12'hf64;
      8'h36:   tint = 12'hf00; // hot end, red
      default: tint = `WHITE_RGB;
    endcase
  end

  // split into channels
  assign o_red   = tint[11:8];
  assign o_green = tint[7:4];
  assign o_blue  = tint[3:0];

endmodule

`default_nettype wire

// ==== rtl/thermal_display_macros.svh ====
`ifndef THERMAL_DISPLAY_MACROS_SVH
`define THERMAL_DISPLAY_MACROS_SVH

// screen rectangles, 1-based and inclusive like the scan counters
`define TENS_X_MIN   321
`define TENS_X_MAX   400
`define ONES_X_MIN   401
`define ONES_X_MAX   480
`define DIGIT_Y_MIN  151   // both digit cells share these rows
`define DIGIT_Y_MAX  270
`define WARN_X_MIN   401
`define WARN_X_MAX   520
`define FIRE_X_MIN   521
`define FIRE_X_MAX   640
`define ALARM_Y_MIN  1     // top strip for the alarm boxes
`define ALARM_Y_MAX  120

// seven-segment cell geometry
`define CELL_W       80
`define CELL_H       120
`define SEG_W        10    // bar thickness
`define MID_TOP      55    // middle bar straddles the centre line
`define MID_BOT      64

// packed as red,green,blue nibbles
`define FIRE_RGB     12'hf00
`define WARN_RGB     12'hf80
`define WHITE_RGB    12'hfff
`define BLACK_RGB    12'h000

`endif

// ==== rtl/thermal_display_pkg.sv ====
`default_nettype none

package thermal_display_pkg;

  // scan position from the vga timing block
  typedef logic [10:0] coord_x_t;
  typedef logic [9:0]  coord_y_t;

  typedef logic [3:0]  bcd_digit_t;   // one decimal digit, 10..15 are not digits
  typedef logic [3:0]  color_chan_t;  // one dac channel

  // position inside an 80x120 glyph cell
  typedef logic [6:0]  cell_x_t;
  typedef logic [6:0]  cell_y_t;

  // panel mode code, same encoding as the panel controller FSM
  typedef enum logic [2:0] {
    MODE_SHUTDOWN = 3'd0,
    MODE_MENU_TMP = 3'd1,
    MODE_WORKING  = 3'd2,
    MODE_MENU_CAM = 3'd3,
    MODE_SHOW_PIC = 3'd7
  } display_mode_t;

  // which rectangle the current pixel falls in
  typedef enum logic [2:0] {
    REGION_NONE,
    REGION_FIRE,
    REGION_WARNING,
    REGION_TENS,
    REGION_ONES
  } screen_region_t;

endpackage

`default_nettype wire

// ==== rtl/thermal_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module thermal_display_top (
  input  wire                                     pixel_clk,
  input  wire                                     i_reset,
  input  wire thermal_display_pkg::coord_x_t       i_x,
  input  wire thermal_display_pkg::coord_y_t       i_y,
  input  wire thermal_display_pkg::display_mode_t  i_mode,
  input  wire thermal_display_pkg::bcd_digit_t     i_tens,
  input  wire thermal_display_pkg::bcd_digit_t     i_ones,
  input  wire                                     i_fire,
  input  wire                                     i_warning,
  output thermal_display_pkg::color_chan_t         o_red,
  output thermal_display_pkg::color_chan_t         o_green,
  output thermal_display_pkg::color_chan_t         o_blue
);

  // stage 1 registers
  thermal_display_pkg::display_mode_t  r_mode;
  thermal_display_pkg::screen_region_t r_region;
  thermal_display_pkg::cell_x_t        r_cell_x;
  thermal_display_pkg::cell_y_t        r_cell_y;
  thermal_display_pkg::bcd_digit_t     r_digit;
  thermal_display_pkg::bcd_digit_t     r_tens;
  thermal_display_pkg::bcd_digit_t     r_ones;

  // combinational between the stages
  logic                                glyph_on;
  thermal_display_pkg::color_chan_t    tint_red, tint_green, tint_blue;

  pixel_input_stage pixel_input_stage_inst (
    .pixel_clk (pixel_clk),
    .i_reset   (i_reset),
    .i_x       (i_x),
    .i_y       (i_y),
    .i_mode    (i_mode),
    .i_tens    (i_tens),
    .i_ones    (i_ones),
    .i_fire    (i_fire),
    .i_warning (i_warning),
    .o_mode    (r_mode),
    .o_region  (r_region),
    .o_cell_x  (r_cell_x),
    .o_cell_y  (r_cell_y),
    .o_digit   (r_digit),
    .o_tens    (r_tens),
    .o_ones    (r_ones)
  );

  digit_glyph_rom digit_glyph_rom_inst (
    .i_digit    (r_digit),
    .i_cell_x   (r_cell_x),
    .i_cell_y   (r_cell_y),
    .o_glyph_on (glyph_on)
  );

  temp_color_map temp_color_map_inst (
    .i_tens  (r_tens),
    .i_ones  (r_ones),
    .o_red   (tint_red),
    .o_green (tint_green),
    .o_blue  (tint_blue)
  );

  pixel_composer pixel_composer_inst (
    .pixel_clk    (pixel_clk),
    .i_reset      (i_reset),
    .i_mode       (r_mode),
    .i_region     (r_region),
    .i_digit      (r_digit),
    .i_glyph_on   (glyph_on),
    .i_tint_red   (tint_red),
    .i_tint_green (tint_green),
    .i_tint_blue  (tint_blue),
    .o_red        (o_red),
    .o_green      (o_green),
    .o_blue       (o_blue)
  );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
rtl/thermal_display_pkg.sv
rtl/pixel_input_stage.sv
rtl/digit_glyph_rom.sv
rtl/temp_color_map.sv
rtl/pixel_composer.sv
rtl/thermal_display_top.sv
test/tb_clock_gen.sv
test/tb_thermal_display.sv

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  // free running, starts low
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// ==== test/tb_thermal_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_thermal_display;

  localparam int NUM_VEC     = 33;
  localparam int NUM_FIELDS  = 10;   // words per golden line
  localparam int NUM_RAND    = 64;
  localparam int RESET_CYC   = 16;
  localparam int LATENCY     = 2;    // sample edge to output edge
  localparam int CLK_NS      = 20;
  localparam int TIMEOUT_CYC = NUM_VEC + NUM_RAND + RESET_CYC + 10;

  logic                                 pixel_clk;
  logic                                 i_reset;
  thermal_display_pkg::coord_x_t        i_x;
  thermal_display_pkg::coord_y_t        i_y;
  thermal_display_pkg::display_mode_t   i_mode;
  thermal_display_pkg::bcd_digit_t      i_tens;
  thermal_display_pkg::bcd_digit_t      i_ones;
  logic                                 i_fire;
  logic                                 i_warning;
  thermal_display_pkg::color_chan_t     o_red, o_green, o_blue;

  logic [15:0] golden_mem [0:NUM_VEC*NUM_FIELDS-1];
  logic [11:0] exp_q [$];    // expected rgb, oldest pixel first
  string       name_q [$];
  integer      seed;
  int          n_checked;

  tb_clock_gen #(.PERIOD_NS(CLK_NS)) clock_gen_inst (.o_clk(pixel_clk));

  thermal_display_top thermal_display_top_inst (
    .pixel_clk (pixel_clk),
    .i_reset   (i_reset),
    .i_x       (i_x),
    .i_y       (i_y),
    .i_mode    (i_mode),
    .i_tens    (i_tens),
    .i_ones    (i_ones),
    .i_fire    (i_fire),
    .i_warning (i_warning),
    .o_red     (o_red),
    .o_green   (o_green),
    .o_blue    (o_blue)
  );

  task automatic check_color(input string test_name, input string chan,
                             input thermal_display_pkg::color_chan_t expected,
                             input thermal_display_pkg::color_chan_t actual);
    if (actual !== expected) begin
      $display("[FAIL] %s %s: expected %h, actual %h", test_name, chan, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "colour mismatch");
    end
  endtask

  // one clock, then compare the pixel driven two edges back
  task automatic step_cycle();
    logic [11:0] exp_rgb;
    string       test_name;
    @(posedge pixel_clk);
    #1;
    if (exp_q.size() >= LATENCY) begin
      exp_rgb   = exp_q.pop_front();
      test_name = name_q.pop_front();
      check_color(test_name, "red", exp_rgb[11:8], o_red);
      check_color(test_name, "green", exp_rgb[7:4], o_green);
      check_color(test_name, "blue", exp_rgb[3:0], o_blue);
      n_checked++;
    end
  endtask

  // lands 2 ns after the edge
  task automatic drive_pixel(input string test_name, input logic [2:0] mode_code,
                             input logic [3:0] tens, input logic [3:0] ones,
                             input logic fire, input logic warning,
                             input logic [10:0] x, input logic [9:0] y,
                             input logic [11:0] exp_rgb);
    #1;
    i_mode    = thermal_display_pkg::display_mode_t'(mode_code);
    i_tens    = tens;
    i_ones    = ones;
    i_fire    = fire;
    i_warning = warning;
    i_x       = x;
    i_y       = y;
    exp_q.push_back(exp_rgb);
    name_q.push_back(test_name);
  endtask

  // hard stop if the stream stalls
  initial begin
    #(TIMEOUT_CYC * CLK_NS);
    $display("timeout: the simulation did not finish in the expected time");
    $display("SIMULATION FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int b;
    // quiet inputs, panel off
    i_reset   = 1'b1;
    i_mode    = thermal_display_pkg::MODE_SHUTDOWN;
    i_x       = '0;
    i_y       = '0;
    i_tens    = '0;
    i_ones    = '0;
    i_fire    = 1'b0;
    i_warning = 1'b0;
    seed      = 32'h45dd5876;
    n_checked = 0;

    $readmemh("test/thermal_display_golden.txt", golden_mem);
    if ($isunknown(golden_mem[NUM_VEC*NUM_FIELDS-1])) begin
      $display("golden vector file is missing or shorter than %0d vectors", NUM_VEC);
      $display("SIMULATION FAILED");
      $fatal(1, "bad golden file");
    end

    // outputs held black through reset
    for (int i = 0; i < RESET_CYC; i++) begin
      @(posedge pixel_clk);
      #1;
      check_color("reset", "red", 4'h0, o_red);
      check_color("reset", "green", 4'h0, o_green);
      check_color("reset", "blue", 4'h0, o_blue);
    end
    #1 i_reset = 1'b0;

    // golden pass, one pixel per clock
    for (int v = 0; v < NUM_VEC; v++) begin
      b = v * NUM_FIELDS;
      step_cycle();
      drive_pixel($sformatf("golden[%0d]", v), golden_mem[b][2:0], golden_mem[b+1][3:0],
                  golden_mem[b+2][3:0], golden_mem[b+3][0], golden_mem[b+4][0],
                  golden_mem[b+5][10:0], golden_mem[b+6][9:0],
                  {golden_mem[b+7][3:0], golden_mem[b+8][3:0], golden_mem[b+9][3:0]});
    end

    // panel off, anything on screen must stay black
    for (int r = 0; r < NUM_RAND; r++) begin
      step_cycle();
      drive_pixel($sformatf("random_shutdown[%0d]", r), 3'd0, $random(seed), $random(seed),
                  $random(seed), $random(seed), $random(seed), $random(seed), 12'h000);
    end

    // push the last real pixels out
    for (int f = 0; f < LATENCY; f++) begin
      step_cycle();
      drive_pixel("flush", 3'd0, 4'h0, 4'h0, 1'b0, 1'b0, 11'd0, 10'd0, 12'h000);
    end

    if (n_checked == NUM_VEC + NUM_RAND) begin
      $display("SIMULATION PASSED");
      $finish;
    end else begin
      $display("only %0d of %0d pixels were compared", n_checked, NUM_VEC + NUM_RAND);
      $display("SIMULATION FAILED");
      $fatal(1, "missing compares");
    end
  end

endmodule

`default_nettype wire

// ==== test/thermal_display_golden.txt ====
// mode tens ones fire warning x y red green blue, all hex
// x and y are 1-based scan positions, rgb is the colour two clocks later
0 3 1 0 0 169 9c 0 0 0
1 3 1 0 0 169 9c 0 0 0
7 3 1 0 0 169 9c 0 0 0
5 3 1 0 0 169 9c 0 0 0
0 3 6 1 1 258 3c 0 0 0
2 3 5 0 0 196 f1 0 0 0
2 3 5 0 0 1dc f1 f 6 4
2 3 6 0 0 196 f1 f 0 0
2 3 6 0 0 169 9c f 0 0
2 3 1 0 0 1b9 9c 0 0 0
2 3 1 0 0 1dc b5 f e 8
2 3 7 0 0 1b9 9c f f f
2 3 7 0 0 1b9 d3 0 0 0
2 2 8 0 0 1b9 d3 9 f 9
2 2 7 0 0 146 f1 0 f 8
2 2 7 0 0 18c f1 0 0 0
2 3 1 0 0 190 d3 f e 8
2 3 1 0 0 191 d3 0 0 0
2 2 7 0 0 18c b5 0 f 8
2 3 1 0 0 18c b5 f e 8
2 3 6 0 0 18c b5 f 0 0
2 4 1 0 0 18c b5 f f f
2 3 0 1 0 258 3c f 0 0
2 3 0 0 0 258 3c 0 0 0
2 3 0 0 1 1c2 3c f 8 0
2 3 0 0 0 1c2 3c 0 0 0
2 3 0 1 0 1c2 3c 0 0 0
2 0 5 0 0 169 9c 0 0 0
2 0 5 0 0 1b9 9c f f f
2 a 3 0 0 169 b5 f f f
2 3 f 0 0 1b9 b5 f f f
2 3 1 0 0 64 12c 0 0 0
2 3 1 0 0 140 97 0 0 0
